/* hw/armPkg.sv */
package armPkg;

  // Datapath widths
  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 4;
  localparam int numRegs      = 16;  // r15 is a plain register here
  localparam int flagWidth    = 4;

  typedef logic [dataWidth-1:0]    dataT;     // Operands, results and instructions
  typedef logic [regAddrWidth-1:0] regAddrT;
  typedef logic [flagWidth-1:0]    flagsT;    // {N, Z, C, V}

  // ALU operations
  typedef enum logic [1:0] {
    aluAdd = 2'b00,
    aluSub = 2'b01,
    aluAnd = 2'b10,
    aluOrr = 2'b11
  } aluOpT;

  // Immediate formats, both zero-extended
  typedef enum logic {
    immByte = 1'b0,  // Instr[7:0]
    immWord = 1'b1   // Instr[11:0]
  } immSrcT;

  // Bypass sources for the E-stage operands
  typedef enum logic [1:0] {
    fwdReg    = 2'b00,  // Value read in D
    fwdResult = 2'b01,  // resultW from writeback
    fwdAluOut = 2'b10   // aluOutM from memory stage
  } fwdSelT;

endpackage

/* hw/regFile.sv */
`timescale 1ns/100ps

module regFile import armPkg::*; (
  input  logic    clk,
  input  regAddrT ra1,
  input  regAddrT ra2,
  input  logic    we,
  input  regAddrT wa,
  input  dataT    wd,
  output dataT    rd1,
  output dataT    rd2
);

  dataT regs [numRegs];  // No reset, contents unknown until written

  // Single write port, rising edge
  always_ff @(posedge clk) begin
    if (we) begin
      regs[wa] <= wd;
    end
  end

  // Write-through so D sees the value W writes this cycle
  assign rd1 = (we && (ra1 == wa)) ? wd : regs[ra1];
  assign rd2 = (we && (ra2 == wa)) ? wd : regs[ra2];

endmodule

/* hw/decodeStage.sv */
`timescale 1ns/100ps

module decodeStage import armPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  dataT    instrF,
  input  logic    stallD,
  input  logic    flushD,
  input  logic    regSrcD,
  input  immSrcT  immSrcD,
  output dataT    instrD,
  output regAddrT ra1D,
  output regAddrT ra2D,
  output regAddrT waD,
  output dataT    extImmD
);

  // Instruction register, flush beats stall
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      instrD <= '0;
    end else if (flushD) begin
      instrD <= '0;                // Bubble
    end else if (!stallD) begin
      instrD <= instrF;
    end
  end

  // Register fields
  assign ra1D = instrD[19:16];                              // Rn
  assign ra2D = regSrcD ? instrD[15:12] : instrD[3:0];      // Rd for stores, else Rm
  assign waD  = instrD[15:12];                              // Rd

  // Immediate extension
  always_comb begin
    case (immSrcD)
      immByte: extImmD = {{(dataWidth-8){1'b0}}, instrD[7:0]};
      immWord: extImmD = {{(dataWidth-12){1'b0}}, instrD[11:0]};
      default: extImmD = '0;
    endcase
  end

endmodule

/* hw/executePath.sv */
`timescale 1ns/100ps

module executePath import armPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  regAddrT ra1D,
  input  regAddrT ra2D,
  input  dataT    extImmD,
  input  logic    aluSrcE,
  input  aluOpT   aluControlE,
  input  fwdSelT  forwardAE,
  input  fwdSelT  forwardBE,
  input  logic    regWriteEn,
  input  regAddrT writeAddr,
  input  dataT    resultW,
  output dataT    aluOutM,
  output dataT    writeDataM,
  output dataT    aluOutW,
  output flagsT   aluFlagsE
);

  dataT rd1D, rd2D;
  dataT rd1E, rd2E, extImmE;
  dataT srcAE, srcBE, writeDataE;
  dataT aluResult;
  logic [dataWidth:0] sumE;  // Extra bit holds the carry
  logic carryE, ovfE;

  // Three-way bypass select
  function automatic dataT bypass(fwdSelT sel, dataT regVal, dataT resW, dataT outM);
    case (sel)
      fwdResult: return resW;
      fwdAluOut: return outM;  // Newest value, distance 1
      default:   return regVal;
    endcase
  endfunction

  regFile regs0 (
    .clk(clk), .ra1(ra1D), .ra2(ra2D),
    .we(regWriteEn), .wa(writeAddr), .wd(resultW),
    .rd1(rd1D), .rd2(rd2D)
  );

  // D/E registers
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rd1E    <= '0;
      rd2E    <= '0;
      extImmE <= '0;
    end else begin
      rd1E    <= rd1D;
      rd2E    <= rd2D;
      extImmE <= extImmD;
    end
  end

  assign srcAE      = bypass(forwardAE, rd1E, resultW, aluOutM);
  assign writeDataE = bypass(forwardBE, rd2E, resultW, aluOutM);  // Also the store data
  assign srcBE      = aluSrcE ? extImmE : writeDataE;

  // ALU
  always_comb begin
    sumE      = '0;
    aluResult = '0;
    carryE    = 1'b0;
    ovfE      = 1'b0;
    case (aluControlE)
      aluAdd: begin
        sumE      = {1'b0, srcAE} + {1'b0, srcBE};
        aluResult = sumE[dataWidth-1:0];
        carryE    = sumE[dataWidth];
        ovfE      = (srcAE[dataWidth-1] == srcBE[dataWidth-1]) &&
                    (aluResult[dataWidth-1] != srcAE[dataWidth-1]);
      end
      aluSub: begin
        // A + ~B + 1, carry out means no borrow
        sumE      = {1'b0, srcAE} + {1'b0, ~srcBE} + 1'b1;
        aluResult = sumE[dataWidth-1:0];
        carryE    = sumE[dataWidth];
        ovfE      = (srcAE[dataWidth-1] != srcBE[dataWidth-1]) &&
                    (aluResult[dataWidth-1] != srcAE[dataWidth-1]);
      end
      aluAnd:  aluResult = srcAE & srcBE;
      default: aluResult = srcAE | srcBE;  // aluOrr
    endcase
  end

  assign aluFlagsE = {aluResult[dataWidth-1], aluResult == '0, carryE, ovfE};  // N Z C V

  // E/M and M/W result registers
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      aluOutM    <= '0;
      writeDataM <= '0;
      aluOutW    <= '0;
    end else begin
      aluOutM    <= aluResult;
      writeDataM <= writeDataE;
      aluOutW    <= aluOutM;
    end
  end

endmodule

/* hw/hazardCompare.sv */
`timescale 1ns/100ps

module hazardCompare import armPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  regAddrT ra1D,
  input  regAddrT ra2D,
  input  regAddrT waD,
  output regAddrT waW,
  output logic    match1EM,
  output logic    match1EW,
  output logic    match2EM,
  output logic    match2EW,
  output logic    match12DE
);

  regAddrT ra1E, ra2E;
  regAddrT waE, waM;

  // Address pipeline, sources stop in E
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ra1E <= '0;
      ra2E <= '0;
      waE  <= '0;
      waM  <= '0;
      waW  <= '0;
    end else begin
      ra1E <= ra1D;
      ra2E <= ra2D;
      waE  <= waD;
      waM  <= waE;
      waW  <= waM;
    end
  end

  // Forwarding candidates for the E operands
  assign match1EM = (waM == ra1E);
  assign match1EW = (waW == ra1E);
  assign match2EM = (waM == ra2E);
  assign match2EW = (waW == ra2E);

  // Load-use check, either D source against the E destination
  assign match12DE = (ra1D == waE) || (ra2D == waE);

endmodule

/* hw/writebackStage.sv */
`timescale 1ns/100ps

module writebackStage import armPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  dataT    readDataM,
  input  dataT    aluOutW,
  input  regAddrT waW,
  input  logic    memToRegW,
  input  logic    regWriteW,
  output dataT    resultW,
  output logic    regWriteEn,
  output regAddrT writeAddr
);

  dataT readDataW;

  // Load data follows its instruction from M into W
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      readDataW <= '0;
    end else begin
      readDataW <= readDataM;
    end
  end

  assign resultW = memToRegW ? readDataW : aluOutW;  // Load or ALU result

  // Register-file write port
  assign regWriteEn = regWriteW;
  assign writeAddr  = waW;

endmodule

/* hw/armDatapath.sv */
`timescale 1ns/100ps

module armDatapath import armPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  dataT    instrF,
  input  logic    regSrcD,      // Store form, second source from Rd field
  input  immSrcT  immSrcD,
  input  logic    aluSrcE,
  input  aluOpT   aluControlE,
  input  fwdSelT  forwardAE,
  input  fwdSelT  forwardBE,
  input  logic    memToRegW,
  input  logic    regWriteW,
  input  logic    stallD,
  input  logic    flushD,
  input  dataT    readDataM,
  output dataT    instrD,
  output dataT    aluOutM,
  output dataT    writeDataM,
  output flagsT   aluFlagsE,
  output logic    match1EM,
  output logic    match1EW,
  output logic    match2EM,
  output logic    match2EW,
  output logic    match12DE
);

  // Decode outputs shared by both branches
  regAddrT ra1D, ra2D, waD;
  dataT    extImmD;

  // Writeback side
  dataT    aluOutW;
  regAddrT waW;
  dataT    resultW;
  logic    regWriteEn;
  regAddrT writeAddr;

  decodeStage decode0 (
    .clk(clk), .rstN(rstN),
    .instrF(instrF), .stallD(stallD), .flushD(flushD),
    .regSrcD(regSrcD), .immSrcD(immSrcD),
    .instrD(instrD), .ra1D(ra1D), .ra2D(ra2D), .waD(waD), .extImmD(extImmD)
  );

  // Operand data path, register file lives in here
  executePath execute0 (
    .clk(clk), .rstN(rstN),
    .ra1D(ra1D), .ra2D(ra2D), .extImmD(extImmD),
    .aluSrcE(aluSrcE), .aluControlE(aluControlE),
    .forwardAE(forwardAE), .forwardBE(forwardBE),
    .regWriteEn(regWriteEn), .writeAddr(writeAddr), .resultW(resultW),
    .aluOutM(aluOutM), .writeDataM(writeDataM), .aluOutW(aluOutW), .aluFlagsE(aluFlagsE)
  );

  hazardCompare hazard0 (
    .clk(clk), .rstN(rstN),
    .ra1D(ra1D), .ra2D(ra2D), .waD(waD), .waW(waW),
    .match1EM(match1EM), .match1EW(match1EW),
    .match2EM(match2EM), .match2EW(match2EW), .match12DE(match12DE)
  );

  // Joins the two branches into the register-file write
  writebackStage writeback0 (
    .clk(clk), .rstN(rstN),
    .readDataM(readDataM), .aluOutW(aluOutW), .waW(waW),
    .memToRegW(memToRegW), .regWriteW(regWriteW),
    .resultW(resultW), .regWriteEn(regWriteEn), .writeAddr(writeAddr)
  );

endmodule

/* bench/clockGen.sv */
`timescale 1ns/100ps

module clockGen (
  output logic clk,
  output logic rstN
);

  localparam realtime halfPeriod = 20ns;  // 40 ns clock

  initial begin
    clk  = 1'b0;
    rstN = 1'b0;
    forever #(halfPeriod) clk = ~clk;
  end

  // Release between edges, so the last edge under reset is clean
  initial begin
    repeat (5) @(posedge clk);
    #10 rstN = 1'b1;
  end

endmodule

/* bench/armDatapath_properties.sv */
`timescale 1ns/100ps

module armDatapathProperties import armPkg::*; (
  input logic clk,
  input logic rstN,
  input logic memToRegW,
  input dataT resultW,
  input dataT readDataM,
  input logic regWriteEn
);

  int failCount = 0;  // Failed assertions so far

  // Load data from M reaches the write port one cycle later
  loadSelect: assert property (@(posedge clk) disable iff (!rstN)
    memToRegW |-> resultW == $past(readDataM))
    else begin
      $error("resultW differs from the load data of the previous cycle");
      failCount++;
    end

  // Write strobe must be a clean level
  strobeKnown: assert property (@(posedge clk) disable iff (!rstN)
    !$isunknown(regWriteEn))
    else begin
      $error("regWriteEn is unknown");
      failCount++;
    end

endmodule

bind writebackStage armDatapathProperties props0 (
  .clk(clk), .rstN(rstN), .memToRegW(memToRegW),
  .resultW(resultW), .readDataM(readDataM), .regWriteEn(regWriteEn)
);

/* bench/armDatapathTb.sv */
`timescale 1ns/100ps

module armDatapathTb import armPkg::*; ();

  localparam int numSlots = 140;  // 16 loads, 3 bubbles, 40 reads, 40 deps, 41 stall/flush
  localparam int margin   = 40;

  logic clk, rstN;
  dataT instrF, readDataM, instrD, aluOutM, writeDataM;
  logic regSrcD, aluSrcE, memToRegW, regWriteW, stallD, flushD;
  immSrcT immSrcD;
  aluOpT aluControlE;
  fwdSelT forwardAE, forwardBE;
  flagsT aluFlagsE;
  logic match1EM, match1EW, match2EM, match2EW, match12DE;

  // Program, one entry per issue slot
  dataT sInstr [numSlots];
  dataT sRead [numSlots];
  dataT sExpRes [numSlots];
  dataT sExpWd [numSlots];  // Store data, the second register operand
  flagsT sExpFlags [numSlots];
  aluOpT sOp [numSlots];
  immSrcT sImm [numSlots];
  fwdSelT sFwdA [numSlots];
  fwdSelT sFwdB [numSlots];
  logic sAluSrc [numSlots];
  logic sMemToReg [numSlots];
  logic sRegWrite [numSlots];
  logic sStall [numSlots];
  logic sFlush [numSlots];
  logic sRegSrc [numSlots];
  logic sCheck [numSlots];

  int cyc = -100;
  int errors = 0;

  // Model of instrD and the address pipeline
  dataT mInstrD, pInstrF;
  regAddrT mRa1E, mRa2E, mWaE, mWaM, mWaW, pRa1D, pRa2D, pWaD, ra1, ra2;
  logic pStall, pFlush, pRstN;

  clockGen clk0 (.clk(clk), .rstN(rstN));

  armDatapath dut0 (
    .clk(clk), .rstN(rstN), .instrF(instrF), .regSrcD(regSrcD), .immSrcD(immSrcD),
    .aluSrcE(aluSrcE), .aluControlE(aluControlE), .forwardAE(forwardAE),
    .forwardBE(forwardBE), .memToRegW(memToRegW), .regWriteW(regWriteW),
    .stallD(stallD), .flushD(flushD), .readDataM(readDataM), .instrD(instrD),
    .aluOutM(aluOutM), .writeDataM(writeDataM), .aluFlagsE(aluFlagsE),
    .match1EM(match1EM), .match1EW(match1EW), .match2EM(match2EM),
    .match2EW(match2EW), .match12DE(match12DE)
  );

  // Expected {N, Z, C, V, result}
  function automatic logic [35:0] refAlu(aluOpT op, dataT a, dataT b);
    dataT r;
    logic c, v;
    c = 1'b0;
    v = 1'b0;
    case (op)
      aluAdd: begin
        {c, r} = {1'b0, a} + {1'b0, b};
        v = (a[31] == b[31]) && (r[31] != a[31]);
      end
      aluSub: begin
        r = a - b;
        c = (a >= b);  // No borrow
        v = (a[31] != b[31]) && (r[31] != a[31]);
      end
      aluAnd: r = a & b;
      default: r = a | b;
    endcase
    return {r[31], r == 32'd0, c, v, r};
  endfunction

  task automatic stopRun();
    errors++;
    $display("Checks failed");
    $fatal(1, "stopping at first mismatch");
  endtask

  task automatic checkData(string name, dataT got, dataT exp);
    if (got !== exp) begin
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
      stopRun();
    end
  endtask

  task automatic checkFlags(string name, flagsT got, flagsT exp);
    if (got !== exp) begin
      $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
      stopRun();
    end
  endtask

  task automatic checkAddrMatch(string name, bit got, bit exp);
    if (got !== exp) begin
      $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
      stopRun();
    end
  endtask

  // Program order model, forwarding picked from producer distance
  task automatic buildProgram();
    dataT newest [numRegs];
    int lastWriter [numRegs];
    regAddrT rn, rd, rm;
    dataT opB;
    logic [35:0] ref36;
    for (int r = 0; r < numRegs; r++) lastWriter[r] = -10;
    for (int j = 0; j < numSlots; j++) begin
      rd = $urandom;
      rn = $urandom;
      sInstr[j] = {12'd0, rn, rd, 12'($urandom)};
      sOp[j] = aluOpT'($urandom);
      sImm[j] = immSrcT'($urandom);
      sAluSrc[j] = $urandom;
      sRead[j] = $urandom;
      {sMemToReg[j], sRegWrite[j], sStall[j], sFlush[j], sRegSrc[j], sCheck[j]} = '0;
      if (j < 16) begin  // Load fill of every register
        sInstr[j][15:12] = regAddrT'(j);
        {sMemToReg[j], sRegWrite[j]} = 2'b11;
      end else if (j < 19) begin
        sInstr[j] = '0;  // Bubbles, so reads need no bypass
      end else if (j < 59) begin
        sCheck[j] = 1'b1;  // Read-only ALU ops
      end else if (j < 99) begin
        sInstr[j][19:16] = sInstr[j - 1 - ($urandom % 3)][15:12];  // Distance 1..3
        {sRegWrite[j], sCheck[j]} = 2'b11;
      end else begin
        sStall[j] = ($urandom % 4) == 0;
        sFlush[j] = ($urandom % 8) == 0;
        sRegSrc[j] = $urandom;
      end
      rn = sInstr[j][19:16];
      rd = sInstr[j][15:12];
      rm = sInstr[j][3:0];
      sFwdA[j] = (lastWriter[rn] == j - 1) ? fwdAluOut :
                 (lastWriter[rn] == j - 2) ? fwdResult : fwdReg;
      sFwdB[j] = (lastWriter[rm] == j - 1) ? fwdAluOut :
                 (lastWriter[rm] == j - 2) ? fwdResult : fwdReg;
      if (j >= 99) begin
        sFwdA[j] = fwdReg;
        sFwdB[j] = fwdReg;
      end
      sExpWd[j] = newest[rm];
      opB = !sAluSrc[j] ? newest[rm] :
            (sImm[j] == immByte) ? dataT'(sInstr[j][7:0]) : dataT'(sInstr[j][11:0]);
      ref36 = refAlu(sOp[j], newest[rn], opB);
      {sExpFlags[j], sExpRes[j]} = ref36;
      if (sRegWrite[j]) begin
        newest[rd] = sMemToReg[j] ? sRead[j] : sExpRes[j];
        lastWriter[rd] = j;
      end
    end
  endtask

  function automatic bit inRange(int i);
    return i >= 0 && i < numSlots;
  endfunction

  initial begin
    void'($urandom(32'heae0_623e));
    {instrF, readDataM, regSrcD, aluSrcE, memToRegW, regWriteW, stallD, flushD} = '0;
    immSrcD = immByte;
    aluControlE = aluAdd;
    forwardAE = fwdReg;
    forwardBE = fwdReg;
    buildProgram();
    @(posedge rstN);
    @(negedge clk);
    checkData("instrD", instrD, '0);
    checkData("aluOutM", aluOutM, '0);
    checkData("writeDataM", writeDataM, '0);
    checkAddrMatch("reset match flags", &{match1EM, match1EW, match2EM, match2EW, match12DE}, 1);
    for (int c = 0; c < numSlots + 5; c++) begin
      @(posedge clk);
      cyc = c;
      instrF <= inRange(c) ? sInstr[c] : '0;
      stallD <= inRange(c) ? sStall[c] : 1'b0;
      flushD <= inRange(c) ? sFlush[c] : 1'b0;
      regSrcD <= inRange(c - 1) ? sRegSrc[c - 1] : 1'b0;
      immSrcD <= inRange(c - 1) ? sImm[c - 1] : immByte;
      aluSrcE <= inRange(c - 2) ? sAluSrc[c - 2] : 1'b0;
      aluControlE <= inRange(c - 2) ? sOp[c - 2] : aluAdd;
      forwardAE <= inRange(c - 2) ? sFwdA[c - 2] : fwdReg;
      forwardBE <= inRange(c - 2) ? sFwdB[c - 2] : fwdReg;
      readDataM <= inRange(c - 3) ? sRead[c - 3] : '0;
      memToRegW <= inRange(c - 4) ? sMemToReg[c - 4] : 1'b0;
      regWriteW <= inRange(c - 4) ? sRegWrite[c - 4] : 1'b0;
    end
    @(posedge clk);  // Last falling-edge compare is done
    if (errors == 0 && dut0.writeback0.props0.failCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Compare at the falling edge, inputs and outputs settled
  always @(negedge clk) begin
    if (!rstN || !pRstN) begin
      {mInstrD, mRa1E, mRa2E, mWaE, mWaM, mWaW} = '0;
    end else begin
      {mWaW, mWaM, mWaE, mRa1E, mRa2E} = {mWaM, mWaE, pWaD, pRa1D, pRa2D};
      if (pFlush) mInstrD = '0;
      else if (!pStall) mInstrD = pInstrF;
    end
    ra1 = mInstrD[19:16];
    ra2 = regSrcD ? mInstrD[15:12] : mInstrD[3:0];
    if (rstN) begin
      checkData("instrD", instrD, mInstrD);
      checkAddrMatch("match1EM", match1EM, mWaM == mRa1E);
      checkAddrMatch("match1EW", match1EW, mWaW == mRa1E);
      checkAddrMatch("match2EM", match2EM, mWaM == mRa2E);
      checkAddrMatch("match2EW", match2EW, mWaW == mRa2E);
      checkAddrMatch("match12DE", match12DE, (ra1 == mWaE) || (ra2 == mWaE));
      if (inRange(cyc - 2) && sCheck[cyc - 2])
        checkFlags("aluFlagsE", aluFlagsE, sExpFlags[cyc - 2]);
      if (inRange(cyc - 3) && sCheck[cyc - 3]) begin
        checkData("aluOutM", aluOutM, sExpRes[cyc - 3]);
        checkData("writeDataM", writeDataM, sExpWd[cyc - 3]);
      end
    end
    {pInstrF, pStall, pFlush, pRstN} = {instrF, stallD, flushD, rstN};
    {pRa1D, pRa2D, pWaD} = {ra1, ra2, mInstrD[15:12]};
  end

  initial begin
    #((numSlots + margin) * 40);
    $display("timeout: the run did not reach its end");
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

endmodule

/* sources.f */
hw/armPkg.sv
hw/regFile.sv
hw/decodeStage.sv
hw/executePath.sv
hw/hazardCompare.sv
hw/writebackStage.sv
hw/armDatapath.sv
bench/clockGen.sv
bench/armDatapath_properties.sv
bench/armDatapathTb.sv
